/* hdl/insn_len_cfg.svh */
`ifndef INSN_LEN_CFG_SVH
`define INSN_LEN_CFG_SVH

// sizing for the length decoder back end

// result queue depth
// upstream starts with this many credits, one per free slot
// in flight items are counted against the same slots
`define LEN_FIFO_DEPTH 4

// credits held toward downstream right after reset
// each len_valid beat spends one, len_credit returns one
`define LEN_DOWN_CREDITS 2

`endif

/* hdl/insn_len_pkg.sv */
`default_nettype none

package insn_len_pkg;

    // width of a byte count, longest instruction here is 12 bytes
    localparam int INSN_LEN_W = 4;

    // modrm byte, mod in the top two bits
    // the middle field is the x86 reg/opcode field
    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
    } modrm_t;

    // sib byte, scale on top
    typedef struct packed {
        logic [1:0] scale;
        logic [2:0] index;
        logic [2:0] base;
    } sib_t;

    // window seen as a one-byte opcode, byte 0 is the msb
    typedef struct packed {
        logic [7:0] opcode;
        modrm_t     modrm;
        sib_t       sib;
        logic [7:0] spare;
    } insn_one_byte_t;

    // window seen after a 0F escape
    typedef struct packed {
        logic [7:0] escape;
        logic [7:0] opcode;
        modrm_t     modrm;
        sib_t       sib;
    } insn_two_byte_t;

    // same 32 bits, decoded one way or the other by byte 0
    typedef union packed {
        insn_one_byte_t one_byte;
        insn_two_byte_t two_byte;
    } insn_window_u;

    typedef enum logic [1:0] {
        DISP_NONE = 2'd0,
        DISP_8    = 2'd1,
        DISP_32   = 2'd2
    } disp_size_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_8    = 2'd1,
        IMM_16   = 2'd2,
        IMM_32   = 2'd3
    } imm_size_e;

endpackage

`default_nettype wire

/* hdl/modrm_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module modrm_detector (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        insn_valid,
    input  wire insn_len_pkg::insn_window_u insn_window,
    output logic                       modrm_present,
    output logic                       sib_present,
    output insn_len_pkg::disp_size_e   disp_size,
    output logic                       decode_valid
);

    import insn_len_pkg::*;

    // one-byte opcodes that carry a modrm byte
    function automatic logic has_modrm_1b(input logic [7:0] op);
        // alu rows 00-3F, low half of each row group
        // 62/63 bound and arpl, 69/6B imul forms
        // 80-8F group 1, test, xchg, mov, lea, pop
        // shift groups, les/lds, mov imm, fpu escapes, groups 3/4/5
        return op inside {
            [8'h00:8'h03], [8'h08:8'h0B], [8'h10:8'h13], [8'h18:8'h1B],
            [8'h20:8'h23], [8'h28:8'h2B], [8'h30:8'h33], [8'h38:8'h3B],
            8'h62, 8'h63, 8'h69, 8'h6B,
            [8'h80:8'h8F],
            8'hC0, 8'hC1, [8'hC4:8'hC7],
            [8'hD0:8'hD3], [8'hD8:8'hDF],
            8'hF6, 8'hF7, 8'hFE, 8'hFF
        };
    endfunction

    // second byte after 0F that carries a modrm byte
    function automatic logic has_modrm_2b(input logic [7:0] op);
        // system groups, control/debug moves, cmovcc
        // mmx moves, setcc, bit ops, shld/shrd, imul, cmpxchg, movzx
        return op inside {
            [8'h00:8'h03], [8'h20:8'h23], [8'h40:8'h4F],
            8'h6F, 8'h70, 8'h7F, [8'h90:8'h9F],
            [8'hA3:8'hA5], [8'hAB:8'hAD], 8'hAF,
            8'hB0, 8'hB1, 8'hB6, 8'hB7, [8'hBA:8'hBF]
        };
    endfunction

    logic       esc;
    logic [7:0] op;
    modrm_t     modrm;
    sib_t       sib;
    logic       modrm_d;
    logic       sib_d;
    disp_size_e disp_d;

    // byte 0 picks which view of the window holds the fields
    assign esc = (insn_window.two_byte.escape == 8'h0F);

    always_comb begin
        if (esc) begin
            op    = insn_window.two_byte.opcode;
            modrm = insn_window.two_byte.modrm;
            sib   = insn_window.two_byte.sib;
        end else begin
            op    = insn_window.one_byte.opcode;
            modrm = insn_window.one_byte.modrm;
            sib   = insn_window.one_byte.sib;
        end
    end

    always_comb begin
        modrm_d = esc ? has_modrm_2b(op) : has_modrm_1b(op);

        // rm 100 with a memory operand escapes to sib
        sib_d = modrm_d && (modrm.mod != 2'b11) && (modrm.rm == 3'b100);

        disp_d = DISP_NONE;
        if (modrm_d) begin
            case (modrm.mod)
                2'b01: disp_d = DISP_8;
                2'b10: disp_d = DISP_32;
                2'b00: begin
                    // rm 101 is absolute disp32, no base register
                    if (modrm.rm == 3'b101) begin
                        disp_d = DISP_32;
                    end
                    // sib base 101 under mod 00 also means disp32
                    if (sib_d && (sib.base == 3'b101)) begin
                        disp_d = DISP_32;
                    end
                end
                // register operand, no displacement
                default: disp_d = DISP_NONE;
            endcase
        end
    end

    // results land at the edge that accepts the window
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decode_valid  <= 1'b0;
            modrm_present <= 1'b0;
            sib_present   <= 1'b0;
            disp_size     <= DISP_NONE;
        end else begin
            decode_valid <= insn_valid;
            // hold the last result when idle
            if (insn_valid) begin
                modrm_present <= modrm_d;
                sib_present   <= sib_d;
                disp_size     <= disp_d;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/imm_size_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_size_decoder (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        insn_valid,
    input  wire insn_len_pkg::insn_window_u insn_window,
    output logic                       escaped,
    output insn_len_pkg::imm_size_e    imm_size
);

    import insn_len_pkg::*;

    logic       esc_d;
    logic [7:0] op1;
    logic [7:0] op2;
    logic [2:0] reg_op1;
    imm_size_e  imm_1b;
    imm_size_e  imm_2b;

    assign esc_d   = (insn_window.two_byte.escape == 8'h0F);
    assign op1     = insn_window.one_byte.opcode;
    assign op2     = insn_window.two_byte.opcode;
    // group 3 needs the reg field to tell test from the unary ops
    assign reg_op1 = insn_window.one_byte.modrm.reg_op;

    // one-byte opcode table
    always_comb begin
        imm_1b = IMM_NONE;
        if ((op1[7:6] == 2'b00) && (op1[2:0] == 3'b100)) begin
            // alu al,imm8 in every row of 00-3F
            imm_1b = IMM_8;
        end else if ((op1[7:6] == 2'b00) && (op1[2:0] == 3'b101)) begin
            // alu eax,imm32
            imm_1b = IMM_32;
        end else if (op1 inside {8'h6A, 8'h6B, [8'h70:8'h7F], 8'h80, 8'h83,
                                 8'hA8, [8'hB0:8'hB7], 8'hC0, 8'hC1, 8'hC6,
                                 8'hCD, 8'hEB}) begin
            imm_1b = IMM_8;
        end else if (op1 inside {8'hC2, 8'hCA}) begin
            // ret imm16
            imm_1b = IMM_16;
        end else if (op1 inside {8'h68, 8'h69, 8'h81, [8'hA0:8'hA3], 8'hA9,
                                 [8'hB8:8'hBF], 8'hC7, 8'hE8, 8'hE9}) begin
            // A0-A3 moffs counted as a 4 byte operand
            imm_1b = IMM_32;
        end else if ((op1 == 8'hF6) && (reg_op1 == 3'b000)) begin
            // test r/m8,imm8
            imm_1b = IMM_8;
        end else if ((op1 == 8'hF7) && (reg_op1 == 3'b000)) begin
            imm_1b = IMM_32;
        end
    end

    // 0F table is short
    always_comb begin
        imm_2b = IMM_NONE;
        if ((op2 == 8'h70) || (op2 == 8'hBA)) begin
            // pshufw and bt group take imm8
            imm_2b = IMM_8;
        end else if (op2[7:4] == 4'h8) begin
            // jcc rel32
            imm_2b = IMM_32;
        end
    end

    // same edge as modrm_detector, its decode_valid covers both
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            escaped  <= 1'b0;
            imm_size <= IMM_NONE;
        end else if (insn_valid) begin
            escaped  <= esc_d;
            imm_size <= esc_d ? imm_2b : imm_1b;
        end
    end

endmodule

`default_nettype wire

/* hdl/insn_length_calc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "insn_len_cfg.svh"

module insn_length_calc (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  decode_valid,
    input  wire                                  modrm_present,
    input  wire                                  sib_present,
    input  wire                                  escaped,
    input  wire insn_len_pkg::disp_size_e        disp_size,
    input  wire insn_len_pkg::imm_size_e         imm_size,
    input  wire                                  len_credit,
    output logic                                 len_valid,
    output logic [insn_len_pkg::INSN_LEN_W-1:0]  len_bytes,
    output logic                                 in_credit
);

    import insn_len_pkg::*;

    localparam int DEPTH = `LEN_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`LEN_DOWN_CREDITS + 1);

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    logic [INSN_LEN_W-1:0] op_bytes;
    logic [INSN_LEN_W-1:0] disp_bytes;
    logic [INSN_LEN_W-1:0] imm_bytes;
    logic [INSN_LEN_W-1:0] sum_len;

    logic [INSN_LEN_W-1:0] len_mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      fill;
    logic [CRD_W-1:0]      down_credits;
    logic                  push;
    logic                  pop;

    // size codes to byte counts
    always_comb begin
        op_bytes = escaped ? INSN_LEN_W'(2) : INSN_LEN_W'(1);

        case (disp_size)
            DISP_8:  disp_bytes = INSN_LEN_W'(1);
            DISP_32: disp_bytes = INSN_LEN_W'(4);
            default: disp_bytes = '0;
        endcase

        case (imm_size)
            IMM_8:   imm_bytes = INSN_LEN_W'(1);
            IMM_16:  imm_bytes = INSN_LEN_W'(2);
            IMM_32:  imm_bytes = INSN_LEN_W'(4);
            default: imm_bytes = '0;
        endcase

        // max 2+1+1+4+4 = 12, fits in 4 bits
        sum_len = op_bytes + INSN_LEN_W'(modrm_present) + INSN_LEN_W'(sib_present)
                + disp_bytes + imm_bytes;
    end

    // upstream credits guarantee a free slot, so every valid result is written
    assign push = decode_valid;

    // a beat needs a queued result and a downstream credit
    assign len_valid = (fill != '0) && (down_credits != '0);
    assign pop       = len_valid;
    assign len_bytes = len_mem[rd_ptr];

    // queue storage
    always_ff @(posedge clk) begin
        if (push) begin
            len_mem[wr_ptr] <= sum_len;
        end
    end

    // queue pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // downstream credits, spent per beat, returned by len_credit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            down_credits <= CRD_W'(`LEN_DOWN_CREDITS);
        end else begin
            case ({pop, len_credit})
                2'b10:   down_credits <= down_credits - 1'b1;
                2'b01:   down_credits <= down_credits + 1'b1;
                default: down_credits <= down_credits;
            endcase
        end
    end

    // slot freed by a pop goes back upstream one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;
        end
    end

endmodule

`default_nettype wire

/* hdl/insn_length_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_length_decoder (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  insn_valid,
    input  wire insn_len_pkg::insn_window_u      insn_window,
    input  wire                                  len_credit,
    output logic                                 in_credit,
    output logic                                 len_valid,
    output logic [insn_len_pkg::INSN_LEN_W-1:0]  len_bytes
);

    import insn_len_pkg::*;

    // stage 1 results, all registered on the accepting edge
    logic       decode_valid;
    logic       modrm_present;
    logic       sib_present;
    logic       escaped;
    disp_size_e disp_size;
    imm_size_e  imm_size;

    // modrm, sib and displacement
    modrm_detector u_modrm_detector (
        .clk           (clk),
        .rst_n         (rst_n),
        .insn_valid    (insn_valid),
        .insn_window   (insn_window),
        .modrm_present (modrm_present),
        .sib_present   (sib_present),
        .disp_size     (disp_size),
        .decode_valid  (decode_valid)
    );

    // escape and immediate, in parallel with the modrm path
    imm_size_decoder u_imm_size_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .insn_valid  (insn_valid),
        .insn_window (insn_window),
        .escaped     (escaped),
        .imm_size    (imm_size)
    );

    // sum, result queue and both credit loops
    insn_length_calc u_insn_length_calc (
        .clk           (clk),
        .rst_n         (rst_n),
        .decode_valid  (decode_valid),
        .modrm_present (modrm_present),
        .sib_present   (sib_present),
        .escaped       (escaped),
        .disp_size     (disp_size),
        .imm_size      (imm_size),
        .len_credit    (len_credit),
        .len_valid     (len_valid),
        .len_bytes     (len_bytes),
        .in_credit     (in_credit)
    );

endmodule

`default_nettype wire

/* tests/tb_insn_length_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "insn_len_cfg.svh"

module tb_insn_length_decoder;

    import insn_len_pkg::*;

    localparam int NUM_RAND = 60;

    logic                  clk;
    logic                  rst_n;
    logic                  insn_valid;
    insn_window_u          insn_window;
    logic                  len_credit;
    logic                  in_credit;
    logic                  len_valid;
    logic [INSN_LEN_W-1:0] len_bytes;

    // expected lengths, oldest first
    int           exp_q[$];
    logic [31:0]  rand_wins[NUM_RAND];
    // one bit per cycle, decides whether a pending downstream credit goes back
    logic [255:0] ret_mask;
    int           up_credits = `LEN_FIFO_DEPTH;
    int           sent_count = 0;
    int           beat_cnt = 0;
    int           ret_cnt = 0;
    int           ret_issued = 0;
    int           in_credit_cnt = 0;
    int           cyc = 0;
    int           accept_cyc = 0;
    int           last_latency = 0;
    int           err_count = 0;
    int           check_count = 0;
    int           test_err_base = 0;

    insn_length_decoder UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .insn_valid  (insn_valid),
        .insn_window (insn_window),
        .len_credit  (len_credit),
        .in_credit   (in_credit),
        .len_valid   (len_valid),
        .len_bytes   (len_bytes)
    );

    always #2 clk = ~clk;

    // length straight from the x86 rules, byte 0 in w[31:24]
    function automatic int ref_len(input logic [31:0] w);
        logic       esc;
        logic [7:0] op;
        logic [1:0] md;
        logic [2:0] reg_f;
        logic [2:0] rm;
        logic [2:0] base;
        logic       has_m;
        int         n;
        esc   = (w[31:24] == 8'h0F);
        // with an escape every field moves one byte down
        op    = esc ? w[23:16] : w[31:24];
        md    = esc ? w[15:14] : w[23:22];
        reg_f = esc ? w[13:11] : w[21:19];
        rm    = esc ? w[10:8] : w[18:16];
        base  = esc ? w[2:0] : w[10:8];
        n     = esc ? 2 : 1;
        if (esc) begin
            has_m = (op[7:4] == 4'h4) || (op[7:4] == 4'h9) || (op[7:2] == 6'b000000)
                  || (op[7:2] == 6'b001000) || (op inside {8'h6F, 8'h70, 8'h7F, 8'hA3,
                     8'hA4, 8'hA5, 8'hAB, 8'hAC, 8'hAD, 8'hAF, 8'hB0, 8'hB1, 8'hB6, 8'hB7})
                  || (op >= 8'hBA && op <= 8'hBF);
        end else begin
            // alu rows, low four of each group of eight
            has_m = (op < 8'h40 && !op[2]) || (op[7:4] == 4'h8) || (op[7:3] == 5'b11011)
                  || (op inside {8'h62, 8'h63, 8'h69, 8'h6B, 8'hC0, 8'hC1, 8'hC4, 8'hC5,
                     8'hC6, 8'hC7, 8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hF6, 8'hF7, 8'hFE, 8'hFF});
        end
        if (has_m) begin
            n += 1;
            if (md != 2'b11 && rm == 3'b100) begin
                n += 1;
            end
            if (md == 2'b01) begin
                n += 1;
            end else if (md == 2'b10) begin
                n += 4;
            end else if (md == 2'b00 && (rm == 3'b101 || (rm == 3'b100 && base == 3'b101))) begin
                n += 4;
            end
        end
        if (esc) begin
            n += (op == 8'h70 || op == 8'hBA) ? 1 : (op[7:4] == 4'h8) ? 4 : 0;
        end else if ((op < 8'h40 && op[2:0] == 3'd4) || (op == 8'hF6 && reg_f == 3'd0)
                     || (op >= 8'h70 && op <= 8'h7F) || (op >= 8'hB0 && op <= 8'hB7)
                     || (op inside {8'h6A, 8'h6B, 8'h80, 8'h83, 8'hA8, 8'hC0, 8'hC1,
                                    8'hC6, 8'hCD, 8'hEB})) begin
            n += 1;
        end else if (op == 8'hC2 || op == 8'hCA) begin
            n += 2;
        end else if ((op < 8'h40 && op[2:0] == 3'd5) || (op == 8'hF7 && reg_f == 3'd0)
                     || (op >= 8'hA0 && op <= 8'hA3) || (op >= 8'hB8)
                     && (op <= 8'hBF) || (op inside {8'h68, 8'h69, 8'h81, 8'hA9, 8'hC7,
                                                     8'hE8, 8'hE9})) begin
            n += 4;
        end
        return n;
    endfunction

    task automatic check_eq(input int actual, input int expected, input string msg);
        check_count++;
        if (actual != expected) begin
            $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, msg, actual, expected);
            err_count++;
        end
    endtask

    // call right after a rising edge, holds a window for one cycle
    task automatic send_window(input logic [31:0] w);
        while (up_credits == 0) begin
            insn_valid <= 1'b0;
            @(posedge clk);
        end
        insn_valid  <= 1'b1;
        insn_window <= w;
        up_credits--;
        sent_count++;
        exp_q.push_back(ref_len(w));
        @(posedge clk);
    endtask

    task automatic wait_drain();
        insn_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // last in_credit pulse lands a cycle after the last beat
        repeat (4) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        check_eq(in_credit_cnt, beat_cnt, {name, ": in_credit pulses vs results"});
        check_eq(up_credits, `LEN_FIFO_DEPTH, {name, ": upstream credits returned"});
        if (err_count == test_err_base) begin
            $display("PASS  %s", name);
        end else begin
            $display("FAIL  %s, %0d errors", name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    // monitor, samples mid cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (insn_valid) begin
                accept_cyc = cyc;
            end
            if (in_credit) begin
                in_credit_cnt++;
                up_credits++;
            end
            if (len_valid) begin
                if (beat_cnt - ret_cnt >= `LEN_DOWN_CREDITS) begin
                    $display("ERROR at %0t ns: result sent with no downstream credit", $time);
                    err_count++;
                end
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t ns: result with no window outstanding", $time);
                    err_count++;
                end else begin
                    check_eq(len_bytes, exp_q.pop_front(), $sformatf("result %0d", beat_cnt));
                end
                last_latency = cyc - accept_cyc;
                beat_cnt++;
            end
            if (len_credit) begin
                ret_cnt++;
            end
        end
    end

    // downstream model, hands credits back on random cycles
    always @(posedge clk) begin
        if (rst_n && beat_cnt > ret_issued && ret_mask[cyc % 256]) begin
            len_credit <= 1'b1;
            ret_issued++;
        end else begin
            len_credit <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > 20 * sent_count + 200) begin
            $display("run timed out after %0d cycles with %0d results missing", cyc, exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [31:0] w;
        clk         = 1'b0;
        rst_n       = 1'b0;
        insn_valid  = 1'b0;
        insn_window = '0;
        len_credit  = 1'b0;
        void'($urandom(98));
        for (int i = 0; i < 8; i++) begin
            ret_mask[i*32 +: 32] = $urandom;
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            w = $urandom;
            // roughly one window in four takes the 0F escape
            if ($urandom % 4 == 0) begin
                w[31:24] = 8'h0F;
            end
            rand_wins[i] = w;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // outputs quiet after reset, then a lone nop
        repeat (3) begin
            @(negedge clk);
            check_eq(len_valid, 0, "len_valid after reset");
            check_eq(in_credit, 0, "in_credit after reset");
        end
        @(posedge clk);
        send_window(32'h90000000);
        wait_drain();
        check_eq(last_latency, 2, "latency of a single window");
        report_test("reset and latency");

        // no modrm, alu imm8/imm32, ret imm16, group 3 test vs not
        send_window(32'h90000000);
        send_window(32'h04110000);
        send_window(32'h05112233);
        send_window(32'h80C01100);
        send_window(32'h81C01122);
        send_window(32'hC2100000);
        send_window(32'hF6C01100);
        send_window(32'hF6D00000);
        send_window(32'hF7C01122);
        send_window(32'hF7D00000);
        wait_drain();
        report_test("one-byte opcode classes");

        // mod 11, sib, disp8, disp32, absolute disp32, sib base 101
        send_window(32'h01C00000);
        send_window(32'h01040000);
        send_window(32'h01451100);
        send_window(32'h01851122);
        send_window(32'h01051122);
        send_window(32'h01042511);
        wait_drain();
        report_test("modrm addressing forms");

        // jcc rel32, bt group imm8, imul with sib base 101
        for (int i = 0; i < 16; i++) begin
            send_window({8'h0F, 8'h80 + 8'(i), 16'h1122});
        end
        send_window(32'h0FBAE011);
        send_window(32'h0FAF0425);
        wait_drain();
        report_test("two-byte opcodes");

        for (int i = 0; i < NUM_RAND; i++) begin
            send_window(rand_wins[i]);
        end
        wait_drain();
        report_test("random back-to-back stream");

        $display("done: %0d windows, %0d checks, %0d errors", sent_count, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/insn_len_pkg.sv
hdl/modrm_detector.sv
hdl/imm_size_decoder.sv
hdl/insn_length_calc.sv
hdl/insn_length_decoder.sv
tests/tb_insn_length_decoder.sv

/* Bender.yml */
package:
  name: insn_length_decoder

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/insn_len_pkg.sv
      - hdl/modrm_detector.sv
      - hdl/imm_size_decoder.sv
      - hdl/insn_length_calc.sv
      - hdl/insn_length_decoder.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_insn_length_decoder.sv
